// ==== rtl/flow_pkg.sv ====
/*
  Shared types and constants for the stream flow router.
  Every RTL block and the testbench refer to these by scoped name.
*/

package flow_pkg;

  // ------------------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------------------

  // Payload word width in bits
  localparam int data_width = 16;

  // Select field width, enough to address max_flows lanes
  localparam int sel_width = 3;

  // ------------------------------------------------------------------------
  // Lane count limits
  // ------------------------------------------------------------------------

  // Upper bound on the number of output lanes
  localparam int max_flows = 8;

  // Lane count used when the top level is not overridden
  localparam int default_num_flows = 4;

  // ------------------------------------------------------------------------
  // Types
  // ------------------------------------------------------------------------

  // One payload word carried by a single transfer
  typedef logic [data_width-1:0] flow_data_t;

  // Destination lane number travelling with each word
  typedef logic [sel_width-1:0] flow_sel_t;

endpackage

// ==== rtl/flow_reg_fwd.sv ====
/*
  One-entry forward pipeline register for a ready-valid stream.
  Breaks the valid/data path and sustains one transfer per cycle.
*/

`timescale 1ns/1ps

module flow_reg_fwd #(
  // Payload width in bits, at least 1
  parameter int width = 1
) (
  input  logic             clk,
  // Synchronous, active high
  input  logic             rst,

  // Upstream side
  output logic             push_ready,
  input  logic             push_valid,
  input  logic [width-1:0] push_data,

  // Downstream side
  input  logic             pop_ready,
  output logic             pop_valid,
  output logic [width-1:0] pop_data
);

  // ------------------------------------------------------------------------
  // Elaboration checks
  // ------------------------------------------------------------------------

  if (width < 1) begin : gen_bad_width
    $error("flow_reg_fwd width must be at least 1");
  end

  // ------------------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------------------

  // Occupancy flag of the single entry
  logic valid_q;

  // Held payload
  logic [width-1:0] data_q;

  // Accept when empty or when the held word leaves this cycle
  // Keeps full throughput without a skid entry
  assign push_ready = !valid_q || pop_ready;

  // Control state
  // When the slot frees up, the next state simply follows push_valid
  // That covers load, refill and drain in one line
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (push_ready) begin
      valid_q <= push_valid;
    end
  end

  // Payload only moves on an accepted transfer
  always_ff @(posedge clk) begin
    if (push_valid && push_ready) begin
      data_q <= push_data;
    end
  end

  // Outputs come straight from the flops
  assign pop_valid = valid_q;
  assign pop_data  = data_q;

  // ------------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------------

  // Entry is empty on the cycle after reset
  empty_after_reset_a : assert property (
    @(posedge clk) rst |=> !pop_valid
  ) else $error("flow_reg_fwd valid set right after reset");

  // A stalled word must not change
  pop_data_held_a : assert property (
    @(posedge clk) disable iff (rst)
    pop_valid && !pop_ready |=> $stable(pop_data)
  ) else $error("flow_reg_fwd changed data while stalled");

endmodule

// ==== rtl/flow_demux_select.sv ====
/*
  Combinational ready-valid demux steered by an explicit select.
  The word fans out to every lane and only the selected lane sees valid.
*/

`timescale 1ns/1ps

module flow_demux_select #(
  // Number of output lanes, from 2 up to flow_pkg::max_flows
  parameter int num_flows = 2
) (
  // Clock and reset feed the checks only
  input  logic                                   clk,
  input  logic                                   rst,

  // Destination lane, qualified by push_valid
  input  flow_pkg::flow_sel_t                    select,

  // Upstream side
  output logic                                   push_ready,
  input  logic                                   push_valid,
  input  flow_pkg::flow_data_t                   push_data,

  // One downstream side per lane
  input  logic                 [num_flows-1:0]   pop_ready,
  output logic                 [num_flows-1:0]   pop_valid,
  output flow_pkg::flow_data_t [num_flows-1:0]   pop_data
);

  // ------------------------------------------------------------------------
  // Elaboration checks
  // ------------------------------------------------------------------------

  if (num_flows < 2 || num_flows > flow_pkg::max_flows) begin : gen_bad_num_flows
    $error("flow_demux_select num_flows must be in 2..max_flows");
  end

  // ------------------------------------------------------------------------
  // Steering
  // ------------------------------------------------------------------------

  // Lane match is decoded per lane
  // An out-of-range select leaves every lane idle and push_ready low
  always_comb begin
    push_ready = 1'b0;
    for (int i = 0; i < num_flows; i++) begin
      // Data is replicated, valid picks the lane that owns it
      pop_data[i]  = push_data;
      pop_valid[i] = push_valid && (select == flow_pkg::flow_sel_t'(i));
      if (select == flow_pkg::flow_sel_t'(i)) begin
        push_ready = pop_ready[i];
      end
    end
  end

  // ------------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------------

  // Source must only address lanes that exist
  select_in_range_a : assert property (
    @(posedge clk) disable iff (rst)
    push_valid |-> select < num_flows
  ) else $error("flow_demux_select select out of range");

  // A pending transfer may not be redirected to another lane
  select_stable_a : assert property (
    @(posedge clk) disable iff (rst)
    push_valid && !push_ready |=> $stable(select)
  ) else $error("flow_demux_select select changed while stalled");

endmodule

// ==== rtl/flow_router_top.sv ====
/*
  Registered stream router. Input register holds word and select,
  the demux picks a lane, and each lane has its own output register.
  Latency is two cycles from push to pop when nothing stalls.
*/

`timescale 1ns/1ps

module flow_router_top #(
  // Number of output lanes
  parameter int num_flows = flow_pkg::default_num_flows
) (
  input  logic                                   clk,
  // Synchronous, active high
  input  logic                                   rst,

  // Input stream
  output logic                                   push_ready,
  input  logic                                   push_valid,
  input  flow_pkg::flow_data_t                   push_data,
  input  flow_pkg::flow_sel_t                    push_select,

  // Output lanes
  input  logic                 [num_flows-1:0]   pop_ready,
  output logic                 [num_flows-1:0]   pop_valid,
  output flow_pkg::flow_data_t [num_flows-1:0]   pop_data
);

  // ------------------------------------------------------------------------
  // Elaboration checks
  // ------------------------------------------------------------------------

  // The select field cannot address more than max_flows lanes
  if (num_flows > flow_pkg::max_flows) begin : gen_too_many_flows
    $error("flow_router_top num_flows exceeds select range");
  end

  // Input register carries select and data side by side
  localparam int in_width = flow_pkg::sel_width + flow_pkg::data_width;

  // ------------------------------------------------------------------------
  // Input stage
  // ------------------------------------------------------------------------

  logic                 in_pop_ready;
  logic                 in_pop_valid;
  logic [in_width-1:0]  in_pop_word;
  flow_pkg::flow_sel_t  in_pop_select;
  flow_pkg::flow_data_t in_pop_data;

  flow_reg_fwd #(
    .width      (in_width)
  ) in_reg (
    .clk        (clk),
    .rst        (rst),
    .push_ready (push_ready),
    .push_valid (push_valid),
    .push_data  ({push_select, push_data}),
    .pop_ready  (in_pop_ready),
    .pop_valid  (in_pop_valid),
    .pop_data   (in_pop_word)
  );

  // Select sits in the upper bits
  assign {in_pop_select, in_pop_data} = in_pop_word;

  // ------------------------------------------------------------------------
  // Lane steering
  // ------------------------------------------------------------------------

  logic                 [num_flows-1:0] lane_ready;
  logic                 [num_flows-1:0] lane_valid;
  flow_pkg::flow_data_t [num_flows-1:0] lane_data;

  flow_demux_select #(
    .num_flows  (num_flows)
  ) demux (
    .clk        (clk),
    .rst        (rst),
    .select     (in_pop_select),
    .push_ready (in_pop_ready),
    .push_valid (in_pop_valid),
    .push_data  (in_pop_data),
    .pop_ready  (lane_ready),
    .pop_valid  (lane_valid),
    .pop_data   (lane_data)
  );

  // ------------------------------------------------------------------------
  // Output stage, one register per lane
  // ------------------------------------------------------------------------

  for (genvar i = 0; i < num_flows; i++) begin : gen_lane
    flow_reg_fwd #(
      .width      (flow_pkg::data_width)
    ) out_reg (
      .clk        (clk),
      .rst        (rst),
      .push_ready (lane_ready[i]),
      .push_valid (lane_valid[i]),
      .push_data  (lane_data[i]),
      .pop_ready  (pop_ready[i]),
      .pop_valid  (pop_valid[i]),
      .pop_data   (pop_data[i])
    );
  end

endmodule

// ==== verif/tb_flow_router.sv ====
/*
  Directed testbench for the stream flow router.
  Drives the input stream on falling edges, models each lane with a
  queue of expected words and checks every pop against it.
*/

`timescale 1ns/1ps

module tb_flow_router;

  localparam int nf          = flow_pkg::default_num_flows;
  localparam int stream_len  = 16;
  localparam int rand_words  = 200;
  // Routing, latency, full-rate stream, back-pressure and random traffic
  localparam int total_words = nf + 1 + stream_len + 4 + rand_words;
  localparam int limit_cycles = total_words * 20 + 100;
  // Longest wait for the lane models to empty once input stops
  localparam int drain_cycles = 50;

  logic                             clk;
  logic                             rst;
  logic                             push_ready;
  logic                             push_valid;
  flow_pkg::flow_data_t             push_data;
  flow_pkg::flow_sel_t              push_select;
  logic                 [nf-1:0]    pop_ready;
  logic                 [nf-1:0]    pop_valid;
  flow_pkg::flow_data_t [nf-1:0]    pop_data;

  // Expected words per lane, oldest first
  flow_pkg::flow_data_t exp_q[nf][$];
  flow_pkg::flow_data_t exp_word;
  string                test_name;
  integer               seed;
  int                   errors;
  int                   n_in;
  int                   n_out;
  int                   stalls;

  flow_router_top #(
    .num_flows   (nf)
  ) dut (
    .clk         (clk),
    .rst         (rst),
    .push_ready  (push_ready),
    .push_valid  (push_valid),
    .push_data   (push_data),
    .push_select (push_select),
    .pop_ready   (pop_ready),
    .pop_valid   (pop_valid),
    .pop_data    (pop_data)
  );

  // 8 ns period
  always #4 clk = !clk;

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------

  task automatic check_data(input string name, input flow_pkg::flow_data_t exp,
                            input flow_pkg::flow_data_t act);
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_lane(input string name, input flow_pkg::flow_sel_t exp,
                            input flow_pkg::flow_sel_t act);
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s: expected lane %0d, actual lane %0d", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // --------------------------------------------------------------------------
  // Scoreboard, sampled on the rising edge where every signal is settled
  // --------------------------------------------------------------------------

  always @(posedge clk) begin
    if (!rst) begin
      // Word enters the model of its lane when the input takes it
      if (push_valid && push_ready) begin
        exp_q[push_select].push_back(push_data);
        n_in++;
      end
      for (int i = 0; i < nf; i++) begin
        if (pop_valid[i] && pop_ready[i]) begin
          n_out++;
          if (exp_q[i].size() == 0) begin
            errors++;
            $display("ERROR %s: lane %0d popped %h with no word expected",
                     test_name, i, pop_data[i]);
          end else begin
            exp_word = exp_q[i].pop_front();
            check_data(test_name, exp_word, pop_data[i]);
          end
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus helpers, all entered and left on a falling edge
  // --------------------------------------------------------------------------

  // Holds the word on the input until the handshake, counting stall edges
  task automatic send_word(input flow_pkg::flow_data_t d, input flow_pkg::flow_sel_t s);
    push_valid  = 1'b1;
    push_data   = d;
    push_select = s;
    @(posedge clk);
    while (!push_ready) begin
      stalls++;
      @(posedge clk);
    end
    @(negedge clk);
  endtask

  task automatic wait_any_pop(output flow_pkg::flow_sel_t lane, output int hits);
    @(negedge clk);
    while (pop_valid == '0) @(negedge clk);
    hits = 0;
    lane = '0;
    for (int i = 0; i < nf; i++) begin
      if (pop_valid[i]) begin
        hits++;
        lane = flow_pkg::flow_sel_t'(i);
      end
    end
  endtask

  // Returns once every lane model is empty, or gives up after drain_cycles
  task automatic wait_drain();
    int pending;
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      pending = 0;
      for (int i = 0; i < nf; i++) pending += exp_q[i].size();
    end while (pending != 0 && cycles < drain_cycles);
    if (pending != 0) begin
      errors++;
      $display("ERROR %s: %0d expected words never left the DUT", test_name, pending);
    end
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------

  task automatic test_reset_state();
    test_name = "reset_state";
    for (int i = 0; i < nf; i++) check_flag("reset_state pop_valid", 1'b0, pop_valid[i]);
    check_flag("reset_state push_ready", 1'b1, push_ready);
  endtask

  task automatic test_routing();
    flow_pkg::flow_sel_t lane;
    int                  hits;
    test_name = "routing";
    pop_ready = '1;
    for (int k = 0; k < nf; k++) begin
      send_word(flow_pkg::flow_data_t'(16'hA500 + k), flow_pkg::flow_sel_t'(k));
      push_valid = 1'b0;
      wait_any_pop(lane, hits);
      check_lane(test_name, flow_pkg::flow_sel_t'(k), lane);
      if (hits != 1) begin
        errors++;
        $display("ERROR routing: word for lane %0d raised %0d lanes", k, hits);
      end
    end
    wait_drain();
  endtask

  task automatic test_latency();
    test_name = "latency";
    pop_ready = '1;
    // Accepted at edge N, in the lane register after N+1, popped at edge N+2
    send_word(16'h1A7E, flow_pkg::flow_sel_t'(nf - 1));
    push_valid = 1'b0;
    check_flag("latency after N", 1'b0, pop_valid[nf-1]);
    @(negedge clk);
    check_flag("latency after N+1", 1'b1, pop_valid[nf-1]);
    @(negedge clk);
    check_flag("latency after N+2", 1'b0, pop_valid[nf-1]);
    wait_drain();
    // Full-rate stream must never see push_ready low
    stalls = 0;
    for (int i = 0; i < stream_len; i++) begin
      send_word(flow_pkg::flow_data_t'(16'h5000 + i), flow_pkg::flow_sel_t'(i % nf));
    end
    push_valid = 1'b0;
    if (stalls != 0) begin
      errors++;
      $display("ERROR latency: push_ready fell %0d times during a full-rate stream", stalls);
    end
    wait_drain();
  endtask

  task automatic test_back_pressure();
    int bp;
    int other;
    bp    = 1;
    other = (bp + 1) % nf;
    test_name = "back_pressure";
    pop_ready     = '1;
    pop_ready[bp] = 1'b0;
    // First word parks in the lane register, second one in the input register
    send_word(16'hB001, flow_pkg::flow_sel_t'(bp));
    send_word(16'hB002, flow_pkg::flow_sel_t'(bp));
    push_data   = 16'hB003;
    push_select = flow_pkg::flow_sel_t'(other);
    for (int i = 0; i < 4; i++) begin
      check_flag("back_pressure push_ready", 1'b0, push_ready);
      check_flag("back_pressure stalled lane valid", 1'b1, pop_valid[bp]);
      check_data(test_name, 16'hB001, pop_data[bp]);
      check_flag("back_pressure other lane valid", 1'b0, pop_valid[other]);
      @(negedge clk);
    end
    pop_ready[bp] = 1'b1;
    send_word(16'hB003, flow_pkg::flow_sel_t'(other));
    send_word(16'hB004, flow_pkg::flow_sel_t'((bp + 2) % nf));
    push_valid = 1'b0;
    wait_drain();
  endtask

  task automatic test_random_traffic();
    bit done;
    done = 1'b0;
    test_name = "random_traffic";
    fork
      begin
        for (int i = 0; i < rand_words; i++) begin
          send_word(flow_pkg::flow_data_t'($random(seed)),
                    flow_pkg::flow_sel_t'($unsigned($random(seed)) % nf));
        end
        push_valid = 1'b0;
        done = 1'b1;
      end
      begin
        // Each lane ready about three cycles in four
        while (!done) begin
          for (int i = 0; i < nf; i++) pop_ready[i] = ($random(seed) & 3) != 0;
          @(negedge clk);
        end
      end
    join
    pop_ready = '1;
    wait_drain();
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    push_valid  = 1'b0;
    push_data   = '0;
    push_select = '0;
    pop_ready   = '1;
    seed        = 99465;
    errors      = 0;
    n_in        = 0;
    n_out       = 0;
    stalls      = 0;
    test_name   = "reset";
    repeat (3) @(negedge clk);
    rst = 1'b0;
    test_reset_state();
    @(negedge clk);
    test_routing();
    test_latency();
    test_back_pressure();
    test_random_traffic();
    for (int i = 0; i < nf; i++) begin
      if (exp_q[i].size() != 0) begin
        errors++;
        $display("ERROR end: lane %0d still holds %0d expected words", i, exp_q[i].size());
      end
    end
    $display("tb_flow_router: %0d errors, %0d words in, %0d words out", errors, n_in, n_out);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Watchdog, sized from the total word count
  initial begin
    repeat (limit_cycles) @(posedge clk);
    $display("ERROR watchdog: run did not finish within %0d cycles", limit_cycles);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== build.f ====
rtl/flow_pkg.sv
rtl/flow_reg_fwd.sv
rtl/flow_demux_select.sv
rtl/flow_router_top.sv
verif/tb_flow_router.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the flow router testbench with Verilator, runs it and
# decides pass or fail from the simulation log.

set -u

# Work from the project root so build.f paths resolve
cd "$(dirname "$0")" || exit 1

top=tb_flow_router
build_dir=obj_dir
log_file=sim.log

if ! command -v verilator >/dev/null 2>&1; then
  echo "run_sim: verilator not found on PATH"
  exit 1
fi

# Compile
verilator --binary --timing --assert -Wno-fatal \
  --top-module "${top}" \
  -Mdir "${build_dir}" \
  -o "${top}" \
  -f build.f
status=$?
if [ ${status} -ne 0 ]; then
  echo "run_sim: verilator build failed with status ${status}"
  exit ${status}
fi

if [ ! -x "${build_dir}/${top}" ]; then
  echo "run_sim: simulation binary missing"
  exit 1
fi

# Run, keeping a copy of the output
"./${build_dir}/${top}" 2>&1 | tee "${log_file}"
status=${PIPESTATUS[0]}
if [ ${status} -ne 0 ]; then
  echo "run_sim: simulation exited with status ${status}"
  exit ${status}
fi

# Verdict comes from the log only
if grep -qx "STATUS: PASS" "${log_file}"; then
  echo "run_sim: test passed"
  exit 0
else
  echo "run_sim: test failed, see ${log_file}"
  exit 1
fi
